//--- src.f
+incdir+source
source/n163_pkg.sv
source/n163_bus_if.sv
source/n163_bank_regs.sv
source/n163_irq_counter.sv
source/n163_addr_map.sv
source/n163_mapper.sv
verification/n163_properties.sv
verification/n163_tb.sv

//--- Makefile
LOG := sim.log

.PHONY: help test clean

help:
	@echo "targets:"
	@echo "  test   build with Verilator, run n163_tb and check $(LOG)"
	@echo "  clean  remove obj_dir and $(LOG)"
	@echo "  help   show this list"

test:
	verilator --binary --timing --assert -f src.f --top-module n163_tb -Mdir obj_dir
	./obj_dir/Vn163_tb > $(LOG) 2>&1 || true
	@cat $(LOG)
	@grep -q 'All tests passed!' $(LOG) || (echo "simulation FAILED, see $(LOG)"; exit 1)

clean:
	rm -rf obj_dir $(LOG)

//--- verification/n163_tb.sv
// random cpu/ppu traffic from a fixed LCG seed; one access per ce cycle, stops at the first error
`include "n163_cfg.svh"

module n163_tb
	import n163_pkg::*;
();

	logic clk20;
	logic reset;
	logic cpu_ce;
	logic cpu_write;
	cpu_addr_t cpu_addr;
	cpu_data_t cpu_din;
	ppu_addr_t ppu_addr;
	prg_addr_t prg_addr;
	logic prg_allow;
	cpu_data_t prg_dout;
	logic prg_oe;
	chr_addr_t chr_addr;
	logic ciram_ce;
	logic irq;

	// reference copy of the mapper state
	chr_bank_t m_chr [12];
	prg_bank_t m_prg [3];
	logic [1:0] m_ram_en;
	irq_count_t m_count;
	logic m_irq;

	logic [31:0] lcg_state;
	int errors;

	n163_mapper dut0 (.*);

	initial begin
		clk20 = 1'b0;
		forever #10 clk20 = ~clk20;
	end

	function automatic logic [15:0] next_rand();
		lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
		return lcg_state[31:16]; // low lcg bits repeat quickly
	endfunction

	task automatic report_error(input string msg);
		errors++;
		$display("%s", msg);
		$display("Test failures found");
		$fatal(1, "stopped at first error");
	endtask

	// state change on the edge of a ce cycle
	task automatic model_update(input logic wr, input cpu_addr_t a, input cpu_data_t d);
		irq_count_t inc;
		logic step;
		inc = m_count + 16'd1;
		step = m_count[15] && (m_count[14:0] != 15'h7fff);
		if (a[15:12] == 4'h5) begin
			m_irq = 1'b0; // read or write acknowledges
		end else if (m_count == 16'hffff) begin
			m_irq = 1'b1;
		end
		if (wr && a[15:11] == 5'b01010) begin
			m_count[7:0] = d;
		end else if (step) begin
			m_count[7:0] = inc[7:0];
		end
		if (wr && a[15:11] == 5'b01011) begin
			m_count[15:8] = d;
		end else if (step) begin
			m_count[15:8] = inc[15:8];
		end
		if (wr) begin
			if (a[15:14] == 2'b10) begin
				m_chr[{1'b0, a[13:11]}] = d;
			end else if (a[15:13] == 3'b110) begin
				m_chr[{2'b10, a[12:11]}] = d;
			end
			case (a[15:11])
				5'b11100: m_prg[0] = d[5:0];
				5'b11101: begin
					m_prg[1] = d[5:0];
					m_ram_en = d[7:6];
				end
				5'b11110: m_prg[2] = d[5:0];
				default: ;
			endcase
		end
	endtask

	task automatic check_outputs(input logic wr, input cpu_addr_t a, input cpu_data_t d);
		prg_bank_t bank;
		prg_addr_t e_addr;
		logic wram;
		logic e_allow;
		logic e_oe;
		cpu_data_t e_dout;
		chr_bank_t cb;
		chr_addr_t e_chr;
		logic top;
		logic e_ciram;
		wram = (a[15:13] == 3'b011);
		case (a[14:13])
			2'd0: bank = m_prg[0];
			2'd1: bank = m_prg[1];
			2'd2: bank = m_prg[2];
			default: bank = `N163_PRG_FIXED_BANK;
		endcase
		if (!a[15]) begin
			bank[1:0] = 2'b00;
		end
		e_addr = wram ? {`N163_WRAM_PAGE, a[12:0]} : {3'b000, bank, a[12:0]};
		e_allow = (a[15] && !wr) || wram;
		e_oe = !wr && (a[15:12] == 4'h5 || wram || a[15]);
		if (a[15:11] == 5'b01010) begin
			e_dout = m_count[7:0];
		end else if (a[15:11] == 5'b01011) begin
			e_dout = m_count[15:8];
		end else begin
			e_dout = d;
		end
		cb = ppu_addr[13] ? m_chr[{2'b10, ppu_addr[11:10]}] : m_chr[{1'b0, ppu_addr[12:10]}];
		e_chr = {cb, ppu_addr[9:0]};
		top = (cb[7:5] == 3'b111);
		e_ciram = ppu_addr[13] ? top : (top && !m_ram_en[ppu_addr[12]]);

		assert (prg_addr === e_addr) else report_error($sformatf(
			"mismatch at %0t: prg_addr %h, expected %h, cpu %h", $time, prg_addr, e_addr, a));
		assert (prg_allow === e_allow) else report_error($sformatf(
			"mismatch at %0t: prg_allow %b, expected %b, cpu %h", $time, prg_allow, e_allow, a));
		assert (prg_oe === e_oe) else report_error($sformatf(
			"mismatch at %0t: prg_oe %b, expected %b, cpu %h", $time, prg_oe, e_oe, a));
		assert (prg_dout === e_dout) else report_error($sformatf(
			"mismatch at %0t: prg_dout %h, expected %h, cpu %h", $time, prg_dout, e_dout, a));
		assert (chr_addr === e_chr) else report_error($sformatf(
			"mismatch at %0t: chr_addr %h, expected %h, ppu %h", $time, chr_addr, e_chr, ppu_addr));
		assert (ciram_ce === e_ciram) else report_error($sformatf(
			"mismatch at %0t: ciram_ce %b, expected %b, ppu %h", $time, ciram_ce, e_ciram, ppu_addr));
	endtask

	// starts 2 units after an edge, ends 2 units after the next one
	task automatic cpu_access(input logic wr, input cpu_addr_t a, input cpu_data_t d);
		cpu_ce = 1'b1;
		cpu_write = wr;
		cpu_addr = a;
		cpu_din = d;
		#1;
		check_outputs(wr, a, d);
		@(posedge clk20);
		model_update(wr, a, d);
		#2;
		cpu_ce = 1'b0;
		assert (irq === m_irq) else report_error($sformatf(
			"mismatch at %0t: irq %b, expected %b after cpu %h", $time, irq, m_irq, a));
	endtask

	// bus busy but ce low, so no state may change on this edge
	task automatic idle_cycle(input logic wr, input cpu_addr_t a, input cpu_data_t d);
		cpu_ce = 1'b0;
		cpu_write = wr;
		cpu_addr = a;
		cpu_din = d;
		#1;
		check_outputs(wr, a, d);
		@(posedge clk20);
		#2;
		assert (irq === m_irq) else report_error($sformatf(
			"mismatch at %0t: irq %b, expected %b after idle %h", $time, irq, m_irq, a));
	endtask

	initial begin
		logic [15:0] r;
		cpu_addr_t a;
		cpu_data_t d;
		int n;
		lcg_state = 32'h5b40c9d9;
		errors = 0;
		m_chr = '{default: 8'h00};
		m_prg = '{default: 6'h00};
		m_ram_en = 2'b00;
		m_count = 16'h0000;
		m_irq = 1'b0;
		reset = 1'b1;
		cpu_ce = 1'b0;
		cpu_write = 1'b0;
		cpu_addr = 16'h0000;
		cpu_din = 8'h00;
		ppu_addr = 14'h0000;
		repeat (8) @(posedge clk20);
		#2;
		reset = 1'b0;

		assert (irq === 1'b0 && prg_oe === 1'b0) else
			report_error("irq or prg_oe is not low after reset");
		cpu_access(1'b0, 16'h8000, 8'h00);
		cpu_access(1'b0, 16'he000, 8'h00); // fixed last bank

		// prg banks and random cpu traffic
		repeat (8) begin
			r = next_rand();
			cpu_access(1'b1, 16'he000, r[7:0]);
			r = next_rand();
			cpu_access(1'b1, 16'he800, r[15:8]);
			r = next_rand();
			cpu_access(1'b1, 16'hf000, r[11:4]);
			repeat (16) begin
				r = next_rand();
				a = next_rand();
				if (r[5:3] == 3'd0) begin
					idle_cycle(1'b1, a, r[15:8]); // write without ce is dropped
				end else begin
					cpu_access(r[2:0] == 3'd0, a, r[15:8]);
				end
			end
		end

		// chr banks, half of them in the ciram range
		repeat (6) begin
			for (int i = 0; i < 12; i++) begin
				r = next_rand();
				d = r[15] ? {3'b111, r[4:0]} : r[7:0];
				a = 16'h8000 + {i[4:0], 11'h000};
				cpu_access(1'b1, a, d);
			end
			r = next_rand();
			cpu_access(1'b1, 16'he800, r[15:8]);
			repeat (24) begin
				r = next_rand();
				ppu_addr = r[13:0];
				cpu_access(1'b0, 16'h8000, 8'h00);
			end
		end

		// counter load and readback
		repeat (16) begin
			r = next_rand();
			cpu_access(1'b1, {5'b01010, r[10:0]}, r[15:8]);
			r = next_rand();
			cpu_access(1'b1, {5'b01011, r[10:0]}, r[15:8]);
			r = next_rand();
			cpu_access(1'b0, {5'b01010, r[10:0]}, r[15:8]);
			r = next_rand();
			cpu_access(1'b0, {5'b01011, r[10:0]}, r[15:8]);
		end

		// irq rise near ffff, then acknowledge
		repeat (4) begin
			r = next_rand();
			cpu_access(1'b1, 16'h5000, {2'b11, r[5:0]});
			cpu_access(1'b1, 16'h5800, 8'hff);
			n = 0;
			while (irq !== 1'b1 && n < 200) begin
				r = next_rand();
				if (n[0]) begin
					idle_cycle(r[0], {4'h5, r[15:4]}, r[11:4]); // no load, no step
				end else begin
					cpu_access(1'b0, 16'h8000, 8'h00);
				end
				n++;
			end
			assert (irq === 1'b1) else report_error("timeout while waiting for irq to rise");
			idle_cycle(1'b1, 16'h5000, 8'h00); // ce low, irq holds
			r = next_rand();
			cpu_access(r[0], {4'h5, r[15:4]}, r[11:4]);
			assert (irq === 1'b0) else report_error("irq still high after a 0x5xxx access");
		end

		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

//--- verification/n163_properties.sv
// bound to every n163_mapper instance; sees only the top level ports, so bank contents are not checked
module n163_properties
	import n163_pkg::*;
(
	input logic clk20,
	input logic reset,
	input cpu_addr_t cpu_addr,
	input logic prg_allow,
	input chr_addr_t chr_addr,
	input logic ciram_ce,
	input logic irq
);

	irq_after_reset: assert property (@(posedge clk20) reset |=> !irq)
		else $error("irq high in the cycle after reset");

	// work ram open for reads and writes alike
	wram_allow: assert property (@(posedge clk20) disable iff (reset)
		(cpu_addr[15:13] == 3'b011) |-> prg_allow)
		else $error("prg_allow low inside the work RAM window");

	ciram_bank: assert property (@(posedge clk20) disable iff (reset)
		ciram_ce |-> (chr_addr[17:15] == 3'b111)) // banks e0 and up
		else $error("ciram_ce with a bank below 0xe0");

endmodule

bind n163_mapper n163_properties props0 (
	.clk20 (clk20),
	.reset (reset),
	.cpu_addr (cpu_addr),
	.prg_allow (prg_allow),
	.chr_addr (chr_addr),
	.ciram_ce (ciram_ce),
	.irq (irq)
);

//--- source/n163_mapper.sv
// no sound, savestates or mirroring variants; cpu accesses are one-cycle ce strobes and never stall
module n163_mapper
	import n163_pkg::*;
(
	input logic clk20,
	input logic reset,
	input logic cpu_ce,
	input logic cpu_write,
	input cpu_addr_t cpu_addr,
	input cpu_data_t cpu_din,
	input ppu_addr_t ppu_addr,
	output prg_addr_t prg_addr,
	output logic prg_allow,
	output cpu_data_t prg_dout,
	output logic prg_oe,
	output chr_addr_t chr_addr,
	output logic ciram_ce,
	output logic irq
);

	irq_count_t count;

	n163_cpu_bus_if cpu_bus ();
	n163_bank_if banks ();

	assign cpu_bus.ce = cpu_ce;
	assign cpu_bus.write = cpu_write;
	assign cpu_bus.addr = cpu_addr;
	assign cpu_bus.data = cpu_din;

	n163_bank_regs u_bank_regs (
		.clk20 (clk20),
		.reset (reset),
		.bus (cpu_bus),
		.banks (banks)
	);

	n163_irq_counter u_irq_counter (
		.clk20 (clk20),
		.reset (reset),
		.bus (cpu_bus),
		.count (count),
		.irq (irq)
	);

	// address maps react in the same cycle as a bank write
	n163_addr_map u_addr_map (
		.bus (cpu_bus),
		.banks (banks),
		.count (count),
		.ppu_addr (ppu_addr),
		.prg_addr (prg_addr),
		.prg_allow (prg_allow),
		.prg_dout (prg_dout),
		.prg_oe (prg_oe),
		.chr_addr (chr_addr),
		.ciram_ce (ciram_ce)
	);

endmodule

//--- source/n163_addr_map.sv
// purely combinational; outputs follow the cpu and ppu addresses without ce, readback only covers the counter
`include "n163_cfg.svh"

module n163_addr_map
	import n163_pkg::*;
(
	n163_cpu_bus_if.sink bus,
	n163_bank_if.user banks,
	input irq_count_t count,
	input ppu_addr_t ppu_addr,
	output prg_addr_t prg_addr,
	output logic prg_allow,
	output cpu_data_t prg_dout,
	output logic prg_oe,
	output chr_addr_t chr_addr,
	output logic ciram_ce
);

	localparam logic [4:0] LO_PFX = `N163_IRQ_LO_ADDR;
	localparam logic [4:0] HI_PFX = `N163_IRQ_HI_ADDR;

	logic is_wram;
	logic is_reg;
	logic read;
	prg_bank_t prg_sel;
	prg_bank_t prg_bank;
	chr_bank_t chr_bank;
	logic ciram_top;
	logic ram_en;

	assign read = !bus.write;
	assign is_wram = (bus.addr[15:13] == 3'b011); // 6000-7fff
	assign is_reg = (bus.addr[15:12] == LO_PFX[4:1]); // 5000-5fff

	always_comb begin
		case (bus.addr[14:13])
			2'd0: prg_sel = banks.prg_bank[0];
			2'd1: prg_sel = banks.prg_bank[1];
			2'd2: prg_sel = banks.prg_bank[2];
			default: prg_sel = `N163_PRG_FIXED_BANK;
		endcase
	end

	// below 8000 the low bank bits are forced off
	assign prg_bank = prg_sel & {4'b1111, {2{bus.addr[15]}}};

	assign prg_addr = is_wram ? {`N163_WRAM_PAGE, bus.addr[12:0]}
		: {3'b000, prg_bank, bus.addr[12:0]};
	assign prg_allow = (bus.addr[15] && read) || is_wram;

	assign prg_oe = read && (is_reg || is_wram || bus.addr[15]);

	always_comb begin
		case (bus.addr[15:11])
			LO_PFX: prg_dout = count[7:0];
			HI_PFX: prg_dout = count[15:8];
			default: prg_dout = bus.data;
		endcase
	end

	// upper 8 KB reuses registers 8-11 twice
	always_comb begin
		if (ppu_addr[13]) begin
			chr_bank = banks.chr_bank[{2'b10, ppu_addr[11:10]}];
		end else begin
			chr_bank = banks.chr_bank[{1'b0, ppu_addr[12:10]}];
		end
	end

	assign chr_addr = {chr_bank, ppu_addr[9:0]};

	assign ciram_top = (chr_bank[7:5] == `N163_CIRAM_TOP);
	assign ram_en = ppu_addr[12] ? banks.chr_ram_en[1] : banks.chr_ram_en[0];

	// pattern tables can keep e0+ as rom when the half's enable bit is set
	assign ciram_ce = ppu_addr[13] ? ciram_top : (ciram_top && !ram_en);

endmodule

//--- source/n163_irq_counter.sv
// counter steps once per ce cycle and stops at 0x7fff with the enable set; irq stays until a 0x5xxx access
`include "n163_cfg.svh"

module n163_irq_counter
	import n163_pkg::*;
(
	input logic clk20,
	input logic reset,
	n163_cpu_bus_if.sink bus,
	output irq_count_t count,
	output logic irq
);

	localparam logic [4:0] LO_PFX = `N163_IRQ_LO_ADDR;
	localparam logic [4:0] HI_PFX = `N163_IRQ_HI_ADDR;

	irq_count_t count_next;
	logic count_up;
	logic lo_wr;
	logic hi_wr;
	logic ack;

	assign count_next = count + 16'd1;
	assign count_up = count[15] & ~&count[14:0]; // holds at ffff
	assign lo_wr = bus.write && (bus.addr[15:11] == LO_PFX);
	assign hi_wr = bus.write && (bus.addr[15:11] == HI_PFX);

	// reads clear it too
	assign ack = (bus.addr[15:12] == LO_PFX[4:1]);

	always_ff @(posedge clk20) begin
		if (reset) begin
			count <= '0;
			irq <= 1'b0;
		end else if (bus.ce) begin
			if (ack) begin
				irq <= 1'b0;
			end else if (count == 16'hffff) begin
				irq <= 1'b1;
			end

			// each byte loads on its own, the other keeps counting
			if (lo_wr) begin
				count[7:0] <= bus.data;
			end else if (count_up) begin
				count[7:0] <= count_next[7:0];
			end

			if (hi_wr) begin
				count[15:8] <= bus.data;
			end else if (count_up) begin
				count[15:8] <= count_next[15:8];
			end
		end
	end

endmodule

//--- source/n163_bank_regs.sv
// only cpu writes in 0x8000-0xF7FF are decoded; mirroring bits at 0xE000 and the sound port are ignored
`include "n163_cfg.svh"

module n163_bank_regs
	import n163_pkg::*;
(
	input logic clk20,
	input logic reset,
	n163_cpu_bus_if.sink bus,
	n163_bank_if.owner banks
);

	logic wr_en;
	logic [3:0] chr_idx;
	logic chr_hit;

	assign wr_en = bus.ce && bus.write;

	// 2 KB steps over 0x8000-0xDFFF, one chr register each
	always_comb begin
		chr_idx = 4'd0;
		chr_hit = 1'b0;
		if (bus.addr[15:14] == 2'b10) begin
			chr_idx = {1'b0, bus.addr[13:11]}; // 8000-b800
			chr_hit = 1'b1;
		end else if (bus.addr[15:13] == 3'b110) begin
			chr_idx = {2'b10, bus.addr[12:11]}; // c000-d800
			chr_hit = 1'b1;
		end
	end

	always_ff @(posedge clk20) begin
		if (reset) begin
			for (int i = 0; i < `N163_CHR_REGS; i++) begin
				banks.chr_bank[i] <= '0;
			end
			for (int j = 0; j < `N163_PRG_REGS; j++) begin
				banks.prg_bank[j] <= '0;
			end
			banks.chr_ram_en <= 2'b00;
		end else if (wr_en) begin
			if (chr_hit) begin
				banks.chr_bank[chr_idx] <= chr_bank_t'(bus.data);
			end
			case (bus.addr[15:11])
				5'b11100: banks.prg_bank[0] <= bus.data[5:0]; // e000
				5'b11101: begin // e800
					banks.prg_bank[1] <= bus.data[5:0];
					banks.chr_ram_en <= bus.data[7:6];
				end
				5'b11110: banks.prg_bank[2] <= bus.data[5:0]; // f000
				default: ; // f800 sound, below 8000 not ours
			endcase
		end
	end

endmodule

//--- source/n163_bus_if.sv
// cpu bus accesses complete in one clk20 cycle with ce high; the bank set is written by one owner only
`include "n163_cfg.svh"

interface n163_cpu_bus_if;

	logic ce; // one-cycle access strobe
	logic write; // level, low means read
	n163_pkg::cpu_addr_t addr;
	n163_pkg::cpu_data_t data;

	modport sink (
		input ce,
		input write,
		input addr,
		input data
	);

endinterface

interface n163_bank_if;

	n163_pkg::chr_bank_t chr_bank [`N163_CHR_REGS];
	n163_pkg::prg_bank_t prg_bank [`N163_PRG_REGS];
	logic [1:0] chr_ram_en; // one bit per pattern table half

	modport owner (
		output chr_bank,
		output prg_bank,
		output chr_ram_en
	);

	modport user (
		input chr_bank,
		input prg_bank,
		input chr_ram_en
	);

endinterface

//--- source/n163_pkg.sv
// widths follow the NES buses and the N163 pinout; none of them are meant to be changed
package n163_pkg;

	// cpu side
	typedef logic [15:0] cpu_addr_t;
	typedef logic [7:0] cpu_data_t;

	// ppu side, 16 KB pattern + nametable space
	typedef logic [13:0] ppu_addr_t;

	// 8 KB PRG bank number
	typedef logic [5:0] prg_bank_t;

	// 1 KB CHR bank number
	typedef logic [7:0] chr_bank_t;

	// bit 15 enables counting, 14:0 is the count
	typedef logic [15:0] irq_count_t;

	// external memory addresses
	typedef logic [21:0] prg_addr_t; // up to 4 MB
	typedef logic [17:0] chr_addr_t; // 256 KB

endpackage

//--- source/n163_cfg.svh
// fixed by the N163 board; register counts and windows must match the decoders that use them
`ifndef N163_CFG_SVH
`define N163_CFG_SVH

// register file size
`define N163_CHR_REGS 12
`define N163_PRG_REGS 3

// 0xE000-0xFFFF always maps here
`define N163_PRG_FIXED_BANK 6'h3f

// work RAM lands at the top of the PRG space
`define N163_WRAM_PAGE 9'h1e0

// CHR bank values 0xE0 and up go to nametable RAM
`define N163_CIRAM_TOP 3'b111

// counter byte prefixes on cpu address bits 15:11
`define N163_IRQ_LO_ADDR 5'b01010
`define N163_IRQ_HI_ADDR 5'b01011

`endif
